// File: hw/cache_ram.sv
module cache_ram #(
	parameter int INDEX_BITS = 6
) (
	input logic i_clock,
	input logic i_write,
	input logic [INDEX_BITS-1:0] i_address,
	input fetch_pkg::cache_entry_t i_wdata,
	output fetch_pkg::cache_entry_t o_rdata
);

	localparam int DEPTH = 1 << INDEX_BITS;

	fetch_pkg::cache_entry_t mem [DEPTH];
	logic [INDEX_BITS-1:0] address_q;

	// Write on the edge, register the address for the read.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_address] <= i_wdata;
		end
		address_q <= i_address;
	end

	// Read data appears one cycle after the address.
	assign o_rdata = mem[address_q];

endmodule

// File: hw/fetch_if.sv
interface fetch_if;

	// Fetch address and request side.
	fetch_pkg::word_t pc;
	logic stall;

	// Instruction word side.
	fetch_pkg::word_t rdata;
	logic ready;
	logic busy;

	modport fetcher (
		output pc,
		output stall,
		input rdata,
		input ready,
		input busy
	);

	modport cache (
		input pc,
		input stall,
		output rdata,
		output ready,
		output busy
	);

endinterface

// File: hw/fetch_pkg.sv
package fetch_pkg;

	// Word width of the core.
	localparam int XLEN = 32;

	// Instruction word or byte address.
	typedef logic [XLEN-1:0] word_t;

	// One cache RAM entry, 64 bits wide.
	// The tag keeps the whole word address, so a hit needs no extra index check.
	typedef struct packed {
		word_t data;
		logic [XLEN-3:0] tag;
		logic valid;
		logic spare;
	} cache_entry_t;

	// Instruction cache states.
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		READ_SETUP = 2'd1,
		READ_BUS = 2'd2,
		INITIALIZE = 2'd3
	} cache_state_t;

endpackage

// File: hw/fetch_top.sv
module fetch_top #(
	parameter int INDEX_BITS = 6,
	parameter fetch_pkg::word_t RESET_PC = 32'h0000_0100,
	parameter int CREDITS = 4
) (
	input logic i_clock,
	input logic i_reset,

	// Decode side.
	input logic i_redirect,
	input fetch_pkg::word_t i_redirect_pc,
	input logic i_credit_return,
	output logic o_instr_valid,
	output fetch_pkg::word_t o_instr,
	output fetch_pkg::word_t o_instr_pc,

	// Memory bus.
	output logic o_bus_request,
	output fetch_pkg::word_t o_bus_address,
	input logic i_bus_ready,
	input fetch_pkg::word_t i_bus_rdata,

	// Debug counters.
	output logic [31:0] o_hit_count,
	output logic [31:0] o_miss_count
);

	fetch_if fetch_link ();

	fetch_unit #(
		.RESET_PC(RESET_PC),
		.CREDITS(CREDITS)
	) i_fetch_unit (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_redirect(i_redirect),
		.i_redirect_pc(i_redirect_pc),
		.i_credit_return(i_credit_return),
		.o_instr_valid(o_instr_valid),
		.o_instr(o_instr),
		.o_instr_pc(o_instr_pc),
		.fetch(fetch_link)
	);

	icache #(
		.INDEX_BITS(INDEX_BITS)
	) i_icache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.fetch(fetch_link),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.o_hit_count(o_hit_count),
		.o_miss_count(o_miss_count)
	);

endmodule

// File: hw/fetch_unit.sv
module fetch_unit #(
	parameter fetch_pkg::word_t RESET_PC = 32'h0000_0100,
	parameter int CREDITS = 4
) (
	input logic i_clock,
	input logic i_reset,

	input logic i_redirect,
	input fetch_pkg::word_t i_redirect_pc,
	input logic i_credit_return,

	output logic o_instr_valid,
	output fetch_pkg::word_t o_instr,
	output fetch_pkg::word_t o_instr_pc,

	fetch_if.fetcher fetch
);

	localparam int CW = $clog2(CREDITS + 1);

	fetch_pkg::word_t pc;
	fetch_pkg::word_t redirect_pc;
	logic redirect_pending;
	logic [CW-1:0] credits;
	logic [CW-1:0] credits_next;
	logic no_credit;
	logic capture;

	assign fetch.pc = pc;

	// The word held in o_instr_valid has not been charged yet, so count it here.
	assign no_credit = (credits == '0) || (o_instr_valid && (credits == CW'(1)));

	assign fetch.stall = no_credit || redirect_pending;

	// Words from the old path are dropped once a redirect is seen.
	assign capture = fetch.ready && !i_redirect && !redirect_pending;

	always_comb begin
		credits_next = credits;
		if (o_instr_valid && !i_credit_return) begin
			credits_next = credits - 1'b1;
		end else if (!o_instr_valid && i_credit_return) begin
			credits_next = credits + 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pc <= RESET_PC;
			redirect_pending <= 1'b0;
			credits <= CW'(CREDITS);
			o_instr_valid <= 1'b0;
		end else begin
			credits <= credits_next;
			o_instr_valid <= capture;

			if (redirect_pending && !fetch.busy) begin
				// Redirect takes effect, stall is high for this cycle.
				pc <= redirect_pc;
				redirect_pending <= 1'b0;
			end else if (fetch.ready) begin
				pc <= pc + 32'd4;
			end

			if (i_redirect) begin
				redirect_pending <= 1'b1;
			end
		end
	end

	// Target of the latest redirect.
	always_ff @(posedge i_clock) begin
		if (i_redirect) begin
			redirect_pc <= i_redirect_pc;
		end
	end

	// Word and its pc toward decode.
	always_ff @(posedge i_clock) begin
		if (capture) begin
			o_instr <= fetch.rdata;
			o_instr_pc <= pc;
		end
	end

	// Decode never returns more credits than it was granted.
	a_credit_limit: assert property (
		@(posedge i_clock) disable iff (i_reset)
		credits <= CW'(CREDITS)
	);

	// A delivered word always has a credit to spend.
	a_valid_has_credit: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_instr_valid |-> credits != '0
	);

endmodule

// File: hw/icache.sv
module icache #(
	parameter int INDEX_BITS = 6
) (
	input logic i_clock,
	input logic i_reset,

	fetch_if.cache fetch,

	output logic o_bus_request,
	output fetch_pkg::word_t o_bus_address,
	input logic i_bus_ready,
	input fetch_pkg::word_t i_bus_rdata,

	output logic [31:0] o_hit_count,
	output logic [31:0] o_miss_count
);

	fetch_pkg::cache_state_t state;
	fetch_pkg::cache_state_t state_next;

	logic [INDEX_BITS-1:0] clear_index;
	logic [INDEX_BITS-1:0] clear_next;

	logic ram_write;
	logic [INDEX_BITS-1:0] ram_address;
	fetch_pkg::cache_entry_t ram_wdata;
	fetch_pkg::cache_entry_t ram_rdata;

	fetch_pkg::word_t pc_ahead;
	logic hit;
	logic count_hit;
	logic count_miss;

	cache_ram #(
		.INDEX_BITS(INDEX_BITS)
	) i_ram (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_address(ram_address),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata)
	);

	// Address of the next sequential word, used for read-ahead.
	assign pc_ahead = fetch.pc + 32'd4;

	// Entry read last cycle matches the current pc.
	assign hit = ram_rdata.valid && (ram_rdata.tag == fetch.pc[31:2]);

	// The bus always fetches the word at pc.
	assign o_bus_address = fetch.pc;

	assign fetch.busy = (state == fetch_pkg::READ_BUS) || (state == fetch_pkg::INITIALIZE);

	always_comb begin
		state_next = state;
		clear_next = clear_index;

		fetch.ready = 1'b0;
		fetch.rdata = ram_rdata.data;
		o_bus_request = 1'b0;

		ram_write = 1'b0;
		ram_wdata = '0;
		ram_address = fetch.pc[INDEX_BITS+1:2];

		count_hit = 1'b0;
		count_miss = 1'b0;

		case (state)
			fetch_pkg::IDLE: begin
				// RAM is addressed with pc here, so the entry is ready in READ_SETUP.
				if (!fetch.stall) begin
					state_next = fetch_pkg::READ_SETUP;
				end
			end

			fetch_pkg::READ_SETUP: begin
				if (fetch.stall) begin
					state_next = fetch_pkg::IDLE;
				end else if (hit) begin
					fetch.ready = 1'b1;
					count_hit = 1'b1;
					// Read ahead so the next word can hit on the following cycle.
					ram_address = pc_ahead[INDEX_BITS+1:2];
				end else begin
					o_bus_request = 1'b1;
					state_next = fetch_pkg::READ_BUS;
				end
			end

			fetch_pkg::READ_BUS: begin
				o_bus_request = 1'b1;
				fetch.rdata = i_bus_rdata;
				if (i_bus_ready) begin
					// Deliver the bus word and fill its entry in the same cycle.
					fetch.ready = 1'b1;
					count_miss = 1'b1;
					ram_write = 1'b1;
					ram_wdata.data = i_bus_rdata;
					ram_wdata.tag = fetch.pc[31:2];
					ram_wdata.valid = 1'b1;
					ram_wdata.spare = 1'b0;
					state_next = fetch_pkg::IDLE;
				end
			end

			fetch_pkg::INITIALIZE: begin
				// One invalid entry per cycle.
				ram_write = 1'b1;
				ram_address = clear_index;
				clear_next = clear_index + 1'b1;
				if (clear_index == '1) begin
					state_next = fetch_pkg::IDLE;
				end
			end

			default: begin
				state_next = fetch_pkg::INITIALIZE;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::INITIALIZE;
			clear_index <= '0;
			o_hit_count <= '0;
			o_miss_count <= '0;
		end else begin
			state <= state_next;
			clear_index <= clear_next;
			// Only completed lookups are counted.
			if (count_hit) begin
				o_hit_count <= o_hit_count + 32'd1;
			end
			if (count_miss) begin
				o_miss_count <= o_miss_count + 32'd1;
			end
		end
	end

	// A pending request keeps its address, which the fetch unit must hold steady.
	property p_bus_address_stable;
		@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus_address);
	endproperty

	a_bus_address_stable: assert property (p_bus_address_stable);

endmodule

// File: project.f
hw/fetch_pkg.sv
hw/fetch_if.sv
hw/cache_ram.sv
hw/icache.sv
hw/fetch_unit.sv
hw/fetch_top.sv
testbench/tb_bus_model.sv
testbench/tb_fetch.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass message in the log.
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch \
	-f project.f -Mdir build -o sim_fetch > build.log 2>&1 \
	&& ./build/sim_fetch > sim.log 2>&1 \
	|| { echo "Build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "Test completed successfully" sim.log && exit 0 || exit 1

// File: testbench/fetch_stim.txt
# Commands: hold N | fetch N | grant N | wait_request | redirect ADDR (hex)
# bus N (total bus requests) | hits N (total hits) | done NAME
# Cold fetch with credits held, then the stream resumes.
hold 120
fetch 8
bus 12
hits 0
done cold_fetch_and_credits
# Warm refetch of the same words, all hits.
redirect 100
fetch 12
bus 12
hits 12
done warm_refetch
# Redirect while a miss is on the bus.
grant 4
wait_request
redirect 200
fetch 6
bus 19
hits 12
done redirect_during_miss
# Addresses 0x100 and 0x200 share index 0.
redirect 100
fetch 1
bus 20
redirect 200
fetch 1
bus 21
redirect 100
fetch 1
bus 22
hits 12
done index_conflict

// File: testbench/tb_bus_model.sv
module tb_bus_model (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input fetch_pkg::word_t i_address,
	output logic o_ready,
	output fetch_pkg::word_t o_rdata,
	output int o_request_count
);

	int seed;
	int delay;

	// Memory contents follow a fixed rule of the address.
	function automatic fetch_pkg::word_t memory_word(input fetch_pkg::word_t address);
		return address ^ 32'hA5A5_0000;
	endfunction

	// Answers one request at a time, 1 to 4 cycles after it is first seen.
	initial begin
		seed = 64688;
		o_ready = 1'b0;
		o_rdata = '0;
		o_request_count = 0;
		forever begin
			@(negedge i_clock);
			o_ready = 1'b0;
			if (!i_reset && i_request) begin
				delay = 1 + ($unsigned($random(seed)) % 4);
				repeat (delay) begin
					@(negedge i_clock);
				end
				o_rdata = memory_word(i_address);
				o_ready = 1'b1;
				o_request_count = o_request_count + 1;
			end
		end
	end

endmodule

// File: testbench/tb_fetch.sv
module tb_fetch;

	localparam int INDEX_BITS = 6;
	localparam fetch_pkg::word_t RESET_PC = 32'h0000_0100;
	localparam int CREDITS = 4;
	localparam int CLEAR_CYCLES = 1 << INDEX_BITS;
	localparam int TIMEOUT = 2000;

	logic clock;
	logic reset;
	logic redirect;
	fetch_pkg::word_t redirect_pc;
	logic credit_return;
	logic instr_valid;
	fetch_pkg::word_t instr;
	fetch_pkg::word_t instr_pc;
	logic bus_request;
	fetch_pkg::word_t bus_address;
	logic bus_ready;
	fetch_pkg::word_t bus_rdata;
	logic [31:0] hit_count;
	logic [31:0] miss_count;
	int bus_count;

	int fd;
	int code;
	int value;
	int count;
	int start;
	reg [8*16-1:0] cmd;
	reg [8*32-1:0] name;
	reg [8*128-1:0] line_buf;

	int errors;
	int test_start;
	int tests;
	int failed_tests;
	int cycles;
	int got;
	int granted;
	int target;
	bit holding;
	bit timed_out;
	fetch_pkg::word_t exp_pc;

	fetch_top #(
		.INDEX_BITS(INDEX_BITS),
		.RESET_PC(RESET_PC),
		.CREDITS(CREDITS)
	) i_dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_redirect(redirect),
		.i_redirect_pc(redirect_pc),
		.i_credit_return(credit_return),
		.o_instr_valid(instr_valid),
		.o_instr(instr),
		.o_instr_pc(instr_pc),
		.o_bus_request(bus_request),
		.o_bus_address(bus_address),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata),
		.o_hit_count(hit_count),
		.o_miss_count(miss_count)
	);

	tb_bus_model i_bus (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(bus_request),
		.i_address(bus_address),
		.o_ready(bus_ready),
		.o_rdata(bus_rdata),
		.o_request_count(bus_count)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#50 clock = ~clock;
		end
	end

	// One falling edge: check the delivered word, then drive redirect and credits.
	task automatic step();
		@(negedge clock);
		cycles++;
		if (cycles <= CLEAR_CYCLES && (instr_valid || bus_request)) begin
			$display("Valid or bus request seen at %0t while the cache was clearing", $time);
			errors++;
		end
		if (instr_valid) begin
			if (instr_pc !== exp_pc) begin
				$display("MISMATCH at %0t: o_instr_pc expected %h got %h", $time, exp_pc, instr_pc);
				errors++;
			end
			if (instr !== (exp_pc ^ 32'hA5A5_0000)) begin
				$display("MISMATCH at %0t: o_instr expected %h got %h", $time,
					exp_pc ^ 32'hA5A5_0000, instr);
				errors++;
			end
			exp_pc = exp_pc + 32'd4;
			got++;
		end
		redirect = 1'b0;
		credit_return = 1'b0;
		// Return a credit only while the budget allows and decode has room.
		if (!holding && granted < target && (granted - got) < CREDITS) begin
			credit_return = 1'b1;
			granted++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %0s at %0t", what, $time);
		timed_out = 1'b1;
	endtask

	initial begin
		reset = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		credit_return = 1'b0;
		errors = 0;
		test_start = 0;
		tests = 0;
		failed_tests = 0;
		cycles = 0;
		got = 0;
		granted = CREDITS;
		target = 0;
		holding = 1'b0;
		timed_out = 1'b0;
		exp_pc = RESET_PC;

		fd = $fopen("testbench/fetch_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			errors++;
		end

		repeat (10) begin
			@(negedge clock);
		end
		reset = 1'b0;

		while (fd != 0 && !$feof(fd)) begin
			cmd = '0;
			code = $fscanf(fd, "%s", cmd);
			if (code != 1) begin
				break;
			end
			if (cmd == "#") begin
				code = $fgets(line_buf, fd);
			end else if (cmd == "hold") begin
				code = $fscanf(fd, "%d", value);
				holding = 1'b1;
				start = got;
				repeat (value) begin
					step();
				end
				holding = 1'b0;
				if (got - start > CREDITS) begin
					$display("More than %0d words arrived while credits were held", CREDITS);
					errors++;
				end
			end else if (cmd == "fetch") begin
				code = $fscanf(fd, "%d", value);
				target = got + value;
				count = 0;
				while (got < target && count < TIMEOUT) begin
					step();
					count++;
				end
				if (got < target) begin
					report_timeout("instruction words");
					break;
				end
			end else if (cmd == "grant") begin
				code = $fscanf(fd, "%d", value);
				target = got + value;
			end else if (cmd == "wait_request") begin
				count = 0;
				step();
				while (!bus_request && count < TIMEOUT) begin
					step();
					count++;
				end
				if (!bus_request) begin
					report_timeout("a bus request");
					break;
				end
			end else if (cmd == "redirect") begin
				code = $fscanf(fd, "%h", value);
				redirect = 1'b1;
				redirect_pc = value;
				exp_pc = value;
			end else if (cmd == "bus") begin
				code = $fscanf(fd, "%d", value);
				if (bus_count != value) begin
					$display("MISMATCH at %0t: bus_request_count expected %0d got %0d",
						$time, value, bus_count);
					errors++;
				end
				// Every bus request is one completed miss.
				if (miss_count != value) begin
					$display("MISMATCH at %0t: o_miss_count expected %0d got %0d",
						$time, value, miss_count);
					errors++;
				end
			end else if (cmd == "hits") begin
				code = $fscanf(fd, "%d", value);
				if (hit_count != value) begin
					$display("MISMATCH at %0t: o_hit_count expected %0d got %0d",
						$time, value, hit_count);
					errors++;
				end
			end else if (cmd == "done") begin
				code = $fscanf(fd, "%s", name);
				tests++;
				if (errors != test_start) begin
					failed_tests++;
					$display("%0s: FAIL with %0d errors", name, errors - test_start);
				end else begin
					$display("%0s: ok", name);
				end
				test_start = errors;
			end else begin
				$display("Unknown command %0s in the stimulus file", cmd);
				errors++;
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		$display("Tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0 && !timed_out) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
